// ==== sim.f ====
+incdir+verif
source/decode_pkg.sv
source/dec_if.sv
source/dec_arith.sv
source/dec_flow.sv
source/dec_select.sv
source/id_stage.sv
verif/tb_id_stage.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_id_stage
FILELIST = sim.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "^Done: no errors$$" $(LOG)

lint:
	$(TOOL) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== verif/id_ref_model.svh ====
`ifndef ID_REF_MODEL_SVH
`define ID_REF_MODEL_SVH

typedef struct packed {
    logic [31:0] pc;
    alu_op_e     aluop;
    alu_sel_e    alusel;
    logic [31:0] imm;
    logic        rj_en;
    logic        rk_en;
    logic [4:0]  rj;
    logic [4:0]  rk;
    logic        rd_we;
    logic [4:0]  rd;
    logic        exc;
    exc_cause_e  cause;
} dec_result_t;

// expected decode of one word from the ISA field layout
function automatic dec_result_t predict(input logic [31:0] inst, input logic [31:0] pc,
                                        input logic fexc);
    dec_result_t r;
    logic        hit;
    logic [31:0] si12;
    logic [31:0] ui12;
    logic [31:0] offs16;
    logic [31:0] offs26;
    r = '0;
    r.pc = pc;
    hit = 1'b1;
    si12   = {{20{inst[21]}}, inst[21:10]};
    ui12   = {20'b0, inst[21:10]};
    offs16 = {{14{inst[25]}}, inst[25:10], 2'b00};
    offs26 = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};
    if (inst[31:15] inside {op_3r_add_w, op_3r_sub_w, op_3r_and, op_3r_or, op_3r_xor}) begin
        case (inst[31:15])
            op_3r_add_w: r.aluop = alu_add_w;
            op_3r_sub_w: r.aluop = alu_sub_w;
            op_3r_and:   r.aluop = alu_and;
            op_3r_or:    r.aluop = alu_or;
            default:     r.aluop = alu_xor;
        endcase
        r.alusel = (inst[31:15] inside {op_3r_add_w, op_3r_sub_w}) ? sel_arith : sel_logic;
        r.rj_en = 1'b1;
        r.rk_en = 1'b1;
        r.rj    = inst[9:5];
        r.rk    = inst[14:10];
        r.rd_we = 1'b1;
        r.rd    = inst[4:0];
    end else if (inst[31:15] == op_3r_syscall) begin
        r.aluop = alu_syscall;
    end else if (inst[31:15] == op_3r_break) begin
        r.aluop = alu_break;
    end else if (inst[31:22] inside {op_2ri12_addi_w, op_2ri12_ld_w, op_2ri12_st_w,
                                     op_2ri12_andi, op_2ri12_ori}) begin
        r.rj_en = 1'b1;
        r.rj    = inst[9:5];
        r.rd_we = 1'b1;
        r.rd    = inst[4:0];
        r.imm   = si12;
        case (inst[31:22])
            op_2ri12_addi_w: begin
                r.aluop  = alu_addi_w;
                r.alusel = sel_arith;
            end
            op_2ri12_ld_w: begin
                r.aluop  = alu_ld_w;
                r.alusel = sel_mem;
            end
            op_2ri12_andi: begin
                r.aluop  = alu_andi;
                r.alusel = sel_logic;
                r.imm    = ui12;
            end
            op_2ri12_ori: begin
                r.aluop  = alu_ori;
                r.alusel = sel_logic;
                r.imm    = ui12;
            end
            default: begin
                r.aluop  = alu_st_w;   // store data comes from rd
                r.alusel = sel_mem;
                r.rk_en  = 1'b1;
                r.rk     = inst[4:0];
                r.rd_we  = 1'b0;
                r.rd     = '0;
            end
        endcase
    end else if (inst[31:25] inside {op_1ri20_lu12i_w, op_1ri20_pcaddu12i}) begin
        r.aluop  = (inst[31:25] == op_1ri20_lu12i_w) ? alu_lu12i_w : alu_pcaddu12i;
        r.alusel = sel_arith;
        r.imm    = {inst[24:5], 12'b0};
        r.rd_we  = 1'b1;
        r.rd     = inst[4:0];
    end else if (inst[31:26] inside {op_2ri16_beq, op_2ri16_bne}) begin
        r.aluop  = (inst[31:26] == op_2ri16_beq) ? alu_beq : alu_bne;
        r.alusel = sel_branch;
        r.imm    = offs16;
        r.rj_en  = 1'b1;
        r.rk_en  = 1'b1;
        r.rj     = inst[9:5];
        r.rk     = inst[4:0];
    end else if (inst[31:26] == op_2ri16_jirl) begin
        r.aluop  = alu_jirl;
        r.alusel = sel_jump;
        r.imm    = offs16;
        r.rj_en  = 1'b1;
        r.rj     = inst[9:5];
        r.rd_we  = 1'b1;
        r.rd     = inst[4:0];
    end else if (inst[31:26] inside {op_i26_b, op_i26_bl}) begin
        r.alusel = sel_jump;
        r.imm    = offs26;
        if (inst[31:26] == op_i26_bl) begin
            r.aluop = alu_bl;
            r.rd_we = 1'b1;
            r.rd    = link_reg;
        end else begin
            r.aluop = alu_b;
        end
    end else begin
        hit = 1'b0;
    end
    if (fexc) r.cause = exc_fetch;
    else if (!hit) r.cause = exc_ine;
    else if (r.aluop == alu_syscall) r.cause = exc_sys;
    else if (r.aluop == alu_break) r.cause = exc_brk;
    else r.cause = exc_none;
    r.exc = (r.cause != exc_none);
    if (r.exc) r.rd_we = 1'b0;   // rd field itself stays
    return r;
endfunction

`endif

// ==== verif/tb_id_stage.sv ====
`timescale 1ns/100ps

module tb_id_stage;
    import decode_pkg::*;
    `include "id_ref_model.svh"

    localparam int n_rand  = 200;
    localparam int n_items = n_rand + 40;

    logic clk = 1'b0;
    logic arst_n, in_valid, in_ready, in_fetch_exc, out_valid, out_ready;
    logic [31:0] in_pc, in_inst, out_pc, out_imm;
    alu_op_e     out_aluop;
    alu_sel_e    out_alusel;
    logic        out_rj_en, out_rk_en, out_rd_we, out_exc;
    logic [4:0]  out_rj, out_rk, out_rd;
    exc_cause_e  out_exc_cause;

    dec_result_t got, exp_item;
    dec_result_t exp_q[$];
    string       name_q[$];
    string       test_name, item_name;
    int          seed = 32'h488a;
    int          errors = 0, checked = 0, sent = 0;
    logic        rand_ready = 1'b0;
    logic        ready_next = 1'b1;
    logic [31:0] pc_next = 32'h1c00_0000;

    always #4 clk = ~clk;

    id_stage id_stage_i (.*);

    assign got = {out_pc, out_aluop, out_alusel, out_imm, out_rj_en, out_rk_en, out_rj, out_rk,
                  out_rd_we, out_rd, out_exc, out_exc_cause};

    // random out_ready drawn at the rising edge and driven at the falling edge
    always @(posedge clk) if (rand_ready) ready_next = ($random(seed) & 3) != 0;
    always @(negedge clk) if (rand_ready) out_ready = ready_next;

    // pop before push since both can happen on one edge
    always @(posedge clk) begin
        if (arst_n) begin
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("An output was transferred with no instruction outstanding");
                end else begin
                    exp_item  = exp_q.pop_front();
                    item_name = name_q.pop_front();
                    checked++;
                    assert (got == exp_item) else begin
                        errors++;
                        $display("Error %s: expected %h, actual %h", item_name, exp_item, got);
                    end
                end
            end
            if (in_valid && in_ready) begin
                exp_q.push_back(predict(in_inst, in_pc, in_fetch_exc));
                name_q.push_back(test_name);
            end
        end
    end

    a_hold: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid && !out_ready |=> out_valid && $stable(got))
        else begin
            errors++;
            $display("Output changed while held under back-pressure");
        end
    a_ready: assert property (@(posedge clk) disable iff (!arst_n)
        in_ready == (!out_valid || out_ready))
        else begin
            errors++;
            $display("in_ready does not follow the output stage state");
        end
    a_latency: assert property (@(posedge clk) disable iff (!arst_n)
        in_valid && in_ready |=> out_valid)
        else begin
            errors++;
            $display("Accepted instruction did not appear one cycle later");
        end

    // called at a falling edge, returns at a falling edge
    task automatic send(input logic [31:0] inst, input logic fexc);
        in_valid     = 1'b1;
        in_inst      = inst;
        in_pc        = pc_next;
        in_fetch_exc = fexc;
        pc_next      = pc_next + 4;
        #1;
        while (!in_ready) begin
            @(negedge clk);
            #1;
        end
        @(posedge clk);
        sent++;
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic random_inst(output logic [31:0] inst);
        logic [31:0] w;
        int          k;
        k = $random(seed) & 15;
        w = $random(seed);
        case (k)
            0:  inst = {op_3r_add_w, w[14:0]};
            1:  inst = {op_3r_xor, w[14:0]};
            2:  inst = {op_2ri12_addi_w, w[21:0]};
            3:  inst = {op_2ri12_st_w, w[21:0]};
            4:  inst = {op_2ri12_andi, w[21:0]};
            5:  inst = {op_2ri12_ld_w, w[21:0]};
            6:  inst = {op_1ri20_lu12i_w, w[24:0]};
            7:  inst = {op_2ri16_beq, w[25:0]};
            8:  inst = {op_2ri16_jirl, w[25:0]};
            9:  inst = {op_i26_bl, w[25:0]};
            10: inst = {op_i26_b, w[25:0]};
            11: inst = {op_3r_sub_w, w[14:0]};
            12: inst = {op_3r_syscall, w[14:0]};
            default: inst = w;   // mostly unlisted words
        endcase
    endtask

    initial begin
        logic [31:0] inst;
        arst_n = 1'b0;
        in_valid = 1'b0;
        in_pc = '0;
        in_inst = '0;
        in_fetch_exc = 1'b0;
        out_ready = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        assert (!out_valid && in_ready) else begin
            errors++;
            $display("After reset out_valid or in_ready has the wrong level");
        end

        test_name = "3r_alu";
        send({op_3r_add_w, 5'd2, 5'd1, 5'd3}, 1'b0);
        send({op_3r_sub_w, 5'd31, 5'd17, 5'd4}, 1'b0);
        send({op_3r_and, 5'd5, 5'd6, 5'd7}, 1'b0);
        send({op_3r_or, 5'd8, 5'd9, 5'd10}, 1'b0);
        send({op_3r_xor, 5'd11, 5'd12, 5'd13}, 1'b0);
        test_name = "imm";
        send({op_2ri12_addi_w, 12'h800, 5'd1, 5'd2}, 1'b0);
        send({op_2ri12_ld_w, 12'h7ff, 5'd3, 5'd4}, 1'b0);
        send({op_2ri12_st_w, 12'hffc, 5'd5, 5'd6}, 1'b0);
        send({op_2ri12_andi, 12'hfff, 5'd7, 5'd8}, 1'b0);
        send({op_2ri12_ori, 12'h8a5, 5'd9, 5'd10}, 1'b0);
        send({op_1ri20_lu12i_w, 20'h80001, 5'd11}, 1'b0);
        send({op_1ri20_pcaddu12i, 20'h7ffff, 5'd12}, 1'b0);
        test_name = "flow";
        send({op_2ri16_jirl, 16'hfffe, 5'd1, 5'd20}, 1'b0);
        send({op_2ri16_beq, 16'h8000, 5'd2, 5'd3}, 1'b0);
        send({op_2ri16_bne, 16'h0010, 5'd4, 5'd5}, 1'b0);
        send({op_i26_b, 16'h1234, 10'h200}, 1'b0);   // negative offs26
        send({op_i26_bl, 16'h0004, 10'h001}, 1'b0);
        test_name = "exc";
        send(32'hffff_ffff, 1'b0);
        send(32'h0000_0000, 1'b0);
        send({op_3r_syscall, 15'h0042}, 1'b0);
        send({op_3r_break, 15'h0007}, 1'b0);
        send({op_3r_add_w, 5'd2, 5'd1, 5'd3}, 1'b1);
        send({op_3r_syscall, 15'h0001}, 1'b1);
        send(32'hffff_ffff, 1'b1);

        test_name = "backpressure";
        send({op_i26_bl, 16'h0100, 10'h000}, 1'b0);
        out_ready = 1'b0;   // bl now sits in the output stage
        in_valid = 1'b1;
        in_inst  = {op_3r_or, 5'd1, 5'd2, 5'd3};
        in_pc    = pc_next;
        repeat (5) begin
            #1;
            assert (!in_ready) else begin
                errors++;
                $display("in_ready was high while the output stage was stalled");
            end
            @(negedge clk);
        end
        in_valid  = 1'b0;
        out_ready = 1'b1;
        @(negedge clk);

        test_name  = "random";
        rand_ready = 1'b1;
        repeat (n_rand) begin
            while (($random(seed) & 3) == 0) @(negedge clk);
            random_inst(inst);
            send(inst, ($random(seed) & 7) == 0);
        end
        rand_ready = 1'b0;
        out_ready  = 1'b1;
        while (exp_q.size() != 0) @(posedge clk);
        @(negedge clk);
        if (checked != sent) begin
            errors++;
            $display("Sent %0d instructions but only %0d came out", sent, checked);
        end
        $display("sent %0d, checked %0d, errors %0d", sent, checked, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        #((n_items * 20 + 4) * 8);
        $display("Watchdog expired before all instructions came out");
        $display("Done: errors found");
        $finish;
    end

endmodule

// ==== source/id_stage.sv ====
`timescale 1ns/100ps

module id_stage (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic                              in_valid,
    output logic                              in_ready,
    input  logic [decode_pkg::xlen-1:0]       in_pc,
    input  logic [decode_pkg::xlen-1:0]       in_inst,
    input  logic                              in_fetch_exc,
    output logic                              out_valid,
    input  logic                              out_ready,
    output logic [decode_pkg::xlen-1:0]       out_pc,
    output decode_pkg::alu_op_e               out_aluop,
    output decode_pkg::alu_sel_e              out_alusel,
    output logic [decode_pkg::xlen-1:0]       out_imm,
    output logic                              out_rj_en,
    output logic                              out_rk_en,
    output logic [decode_pkg::reg_aw-1:0]     out_rj,
    output logic [decode_pkg::reg_aw-1:0]     out_rk,
    output logic                              out_rd_we,
    output logic [decode_pkg::reg_aw-1:0]     out_rd,
    output logic                              out_exc,
    output decode_pkg::exc_cause_e            out_exc_cause
);

    dec_if u_arith_if ();
    dec_if u_flow_if ();

    // both decoders see the same word
    dec_arith u_dec_arith (
        .inst (in_inst),
        .res  (u_arith_if.fmt)
    );

    dec_flow u_dec_flow (
        .inst (in_inst),
        .res  (u_flow_if.fmt)
    );

    dec_select u_dec_select (
        .clk           (clk),
        .arst_n        (arst_n),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .in_pc         (in_pc),
        .in_fetch_exc  (in_fetch_exc),
        .arith         (u_arith_if.sel),
        .flow          (u_flow_if.sel),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .out_pc        (out_pc),
        .out_aluop     (out_aluop),
        .out_alusel    (out_alusel),
        .out_imm       (out_imm),
        .out_rj_en     (out_rj_en),
        .out_rk_en     (out_rk_en),
        .out_rj        (out_rj),
        .out_rk        (out_rk),
        .out_rd_we     (out_rd_we),
        .out_rd        (out_rd),
        .out_exc       (out_exc),
        .out_exc_cause (out_exc_cause)
    );

endmodule

// ==== source/dec_select.sv ====
`timescale 1ns/100ps

module dec_select (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic                              in_valid,
    output logic                              in_ready,
    input  logic [decode_pkg::xlen-1:0]       in_pc,
    input  logic                              in_fetch_exc,
    dec_if.sel                                arith,
    dec_if.sel                                flow,
    output logic                              out_valid,
    input  logic                              out_ready,
    output logic [decode_pkg::xlen-1:0]       out_pc,
    output decode_pkg::alu_op_e               out_aluop,
    output decode_pkg::alu_sel_e              out_alusel,
    output logic [decode_pkg::xlen-1:0]       out_imm,
    output logic                              out_rj_en,
    output logic                              out_rk_en,
    output logic [decode_pkg::reg_aw-1:0]     out_rj,
    output logic [decode_pkg::reg_aw-1:0]     out_rk,
    output logic                              out_rd_we,
    output logic [decode_pkg::reg_aw-1:0]     out_rd,
    output logic                              out_exc,
    output decode_pkg::exc_cause_e            out_exc_cause
);
    import decode_pkg::*;

    logic              accept;
    alu_op_e           sel_aluop;
    alu_sel_e          sel_alusel;
    logic [xlen-1:0]   sel_imm;
    logic              sel_rj_en;
    logic              sel_rk_en;
    logic [reg_aw-1:0] sel_rj;
    logic [reg_aw-1:0] sel_rk;
    logic              sel_rd_we;
    logic [reg_aw-1:0] sel_rd;
    exc_cause_e        cause;

    assign in_ready = !out_valid || out_ready;   // stage empty or draining
    assign accept   = in_valid && in_ready;

    // flow gives zeros and alu_nop on a miss, which covers the no-hit case
    assign sel_aluop  = arith.hit ? arith.aluop  : flow.aluop;
    assign sel_alusel = arith.hit ? arith.alusel : flow.alusel;
    assign sel_imm    = arith.hit ? arith.imm    : flow.imm;
    assign sel_rj_en  = arith.hit ? arith.rj_en  : flow.rj_en;
    assign sel_rk_en  = arith.hit ? arith.rk_en  : flow.rk_en;
    assign sel_rj     = arith.hit ? arith.rj     : flow.rj;
    assign sel_rk     = arith.hit ? arith.rk     : flow.rk;
    assign sel_rd_we  = arith.hit ? arith.rd_we  : flow.rd_we;
    assign sel_rd     = arith.hit ? arith.rd     : flow.rd;

    always_comb begin
        if (in_fetch_exc) begin
            cause = exc_fetch;   // fetch fault wins over decode
        end else if (!(arith.hit || flow.hit)) begin
            cause = exc_ine;
        end else if (sel_aluop == alu_syscall) begin
            cause = exc_sys;
        end else if (sel_aluop == alu_break) begin
            cause = exc_brk;
        end else begin
            cause = exc_none;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out_pc        <= in_pc;
            out_aluop     <= sel_aluop;
            out_alusel    <= sel_alusel;
            out_imm       <= sel_imm;
            out_rj_en     <= sel_rj_en;
            out_rk_en     <= sel_rk_en;
            out_rj        <= sel_rj;
            out_rk        <= sel_rk;
            out_rd_we     <= sel_rd_we && (cause == exc_none);   // no writeback on exc
            out_rd        <= sel_rd;
            out_exc_cause <= cause;
        end
    end

    assign out_exc = (out_exc_cause != exc_none);

endmodule

// ==== source/dec_flow.sv ====
`timescale 1ns/100ps

module dec_flow (
    input  logic [decode_pkg::xlen-1:0] inst,
    dec_if.fmt                          res
);
    import decode_pkg::*;

    logic [op_2ri16_w-1:0] opc;
    alu_op_e               op;
    logic [xlen-1:0]       offs16;
    logic [xlen-1:0]       offs26;
    logic                  rj_en;
    logic                  rk_en;
    logic                  rd_we;

    assign opc = inst[31:26];

    // word offsets shifted left 2 and sign extended
    assign offs16 = {{(xlen-18){inst[25]}}, inst[25:10], 2'b00};
    assign offs26 = {{(xlen-28){inst[9]}}, inst[9:0], inst[25:10], 2'b00};

    always_comb begin
        case (opc)
            op_2ri16_jirl: op = alu_jirl;
            op_2ri16_beq:  op = alu_beq;
            op_2ri16_bne:  op = alu_bne;
            op_i26_b:      op = alu_b;
            op_i26_bl:     op = alu_bl;
            default:       op = alu_nop;
        endcase
    end

    always_comb begin
        case (op)
            alu_beq, alu_bne:         res.alusel = sel_branch;
            alu_jirl, alu_b, alu_bl:  res.alusel = sel_jump;
            default:                  res.alusel = sel_none;
        endcase
    end

    always_comb begin
        case (op)
            alu_jirl, alu_beq, alu_bne: res.imm = offs16;
            alu_b, alu_bl:              res.imm = offs26;
            default:                    res.imm = '0;
        endcase
    end

    assign rj_en = op inside {alu_jirl, alu_beq, alu_bne};
    assign rk_en = op inside {alu_beq, alu_bne};
    assign rd_we = op inside {alu_jirl, alu_bl};

    assign res.hit   = (op != alu_nop);
    assign res.aluop = op;
    assign res.rj_en = rj_en;
    assign res.rk_en = rk_en;
    assign res.rd_we = rd_we;
    assign res.rj    = rj_en ? inst[9:5] : '0;
    assign res.rk    = rk_en ? inst[4:0] : '0;   // branches compare rj with rd
    assign res.rd    = !rd_we ? '0 : (op == alu_bl) ? link_reg : inst[4:0];

endmodule

// ==== source/dec_arith.sv ====
`timescale 1ns/100ps

module dec_arith (
    input  logic [decode_pkg::xlen-1:0] inst,
    dec_if.fmt                          res
);
    import decode_pkg::*;

    logic [op_3r_w-1:0]    op_3r;
    logic [op_2ri12_w-1:0] op_2ri12;
    logic [op_1ri20_w-1:0] op_1ri20;
    alu_op_e               op;
    logic                  rj_en;
    logic                  rk_en;
    logic                  rd_we;

    assign op_3r    = inst[31:15];
    assign op_2ri12 = inst[31:22];
    assign op_1ri20 = inst[31:25];

    // formats never overlap, so at most one case matches
    always_comb begin
        op = alu_nop;
        case (op_3r)
            op_3r_add_w:   op = alu_add_w;
            op_3r_sub_w:   op = alu_sub_w;
            op_3r_and:     op = alu_and;
            op_3r_or:      op = alu_or;
            op_3r_xor:     op = alu_xor;
            op_3r_syscall: op = alu_syscall;
            op_3r_break:   op = alu_break;
            default:       ;
        endcase
        case (op_2ri12)
            op_2ri12_addi_w: op = alu_addi_w;
            op_2ri12_ld_w:   op = alu_ld_w;
            op_2ri12_st_w:   op = alu_st_w;
            op_2ri12_andi:   op = alu_andi;
            op_2ri12_ori:    op = alu_ori;
            default:         ;
        endcase
        case (op_1ri20)
            op_1ri20_lu12i_w:   op = alu_lu12i_w;
            op_1ri20_pcaddu12i: op = alu_pcaddu12i;
            default:            ;
        endcase
    end

    always_comb begin
        case (op)
            alu_add_w, alu_sub_w, alu_addi_w,
            alu_lu12i_w, alu_pcaddu12i:       res.alusel = sel_arith;
            alu_and, alu_or, alu_xor,
            alu_andi, alu_ori:                res.alusel = sel_logic;
            alu_ld_w, alu_st_w:               res.alusel = sel_mem;
            default:                          res.alusel = sel_none;
        endcase
    end

    always_comb begin
        case (op)
            alu_addi_w, alu_ld_w, alu_st_w: res.imm = {{(xlen-12){inst[21]}}, inst[21:10]};
            alu_andi, alu_ori:              res.imm = {{(xlen-12){1'b0}}, inst[21:10]};
            alu_lu12i_w, alu_pcaddu12i:     res.imm = {inst[24:5], 12'b0};   // si20 << 12
            default:                        res.imm = '0;
        endcase
    end

    assign rj_en = op inside {alu_add_w, alu_sub_w, alu_and, alu_or, alu_xor,
                              alu_addi_w, alu_ld_w, alu_st_w, alu_andi, alu_ori};
    assign rk_en = op inside {alu_add_w, alu_sub_w, alu_and, alu_or, alu_xor, alu_st_w};
    assign rd_we = (op != alu_nop) && !(op inside {alu_syscall, alu_break, alu_st_w});

    assign res.hit   = (op != alu_nop);
    assign res.aluop = op;
    assign res.rj_en = rj_en;
    assign res.rk_en = rk_en;
    assign res.rd_we = rd_we;
    assign res.rj    = rj_en ? inst[9:5] : '0;
    // st.w takes its store data from rd
    assign res.rk    = !rk_en ? '0 : (op == alu_st_w) ? inst[4:0] : inst[14:10];
    assign res.rd    = rd_we ? inst[4:0] : '0;

endmodule

// ==== source/dec_if.sv ====
`timescale 1ns/100ps

interface dec_if;
    import decode_pkg::*;

    logic              hit;
    alu_op_e           aluop;
    alu_sel_e          alusel;
    logic [xlen-1:0]   imm;
    logic              rj_en;
    logic              rk_en;
    logic [reg_aw-1:0] rj;
    logic [reg_aw-1:0] rk;
    logic              rd_we;
    logic [reg_aw-1:0] rd;

    modport fmt (
        output hit, aluop, alusel, imm,
        output rj_en, rk_en, rj, rk, rd_we, rd
    );

    modport sel (
        input hit, aluop, alusel, imm,
        input rj_en, rk_en, rj, rk, rd_we, rd
    );

endinterface

// ==== source/decode_pkg.sv ====
package decode_pkg;

    localparam int xlen   = 32;
    localparam int reg_aw = 5;

    // opcode field widths counted down from bit 31
    localparam int op_3r_w    = 17;
    localparam int op_2ri12_w = 10;
    localparam int op_1ri20_w = 7;
    localparam int op_2ri16_w = 6;
    localparam int op_i26_w   = 6;

    // 3R opcodes in inst[31:15]
    localparam logic [op_3r_w-1:0] op_3r_add_w   = 17'h00020;
    localparam logic [op_3r_w-1:0] op_3r_sub_w   = 17'h00022;
    localparam logic [op_3r_w-1:0] op_3r_and     = 17'h00029;
    localparam logic [op_3r_w-1:0] op_3r_or      = 17'h0002a;
    localparam logic [op_3r_w-1:0] op_3r_xor     = 17'h0002b;
    localparam logic [op_3r_w-1:0] op_3r_break   = 17'h00054;
    localparam logic [op_3r_w-1:0] op_3r_syscall = 17'h00056;

    // 2RI12 opcodes in inst[31:22]
    localparam logic [op_2ri12_w-1:0] op_2ri12_addi_w = 10'h00a;
    localparam logic [op_2ri12_w-1:0] op_2ri12_andi   = 10'h00d;
    localparam logic [op_2ri12_w-1:0] op_2ri12_ori    = 10'h00e;
    localparam logic [op_2ri12_w-1:0] op_2ri12_ld_w   = 10'h0a2;
    localparam logic [op_2ri12_w-1:0] op_2ri12_st_w   = 10'h0a6;

    // 1RI20 opcodes in inst[31:25]
    localparam logic [op_1ri20_w-1:0] op_1ri20_lu12i_w   = 7'h0a;
    localparam logic [op_1ri20_w-1:0] op_1ri20_pcaddu12i = 7'h0e;

    // 2RI16 and I26 share inst[31:26]
    localparam logic [op_2ri16_w-1:0] op_2ri16_jirl = 6'h13;
    localparam logic [op_2ri16_w-1:0] op_2ri16_beq  = 6'h16;
    localparam logic [op_2ri16_w-1:0] op_2ri16_bne  = 6'h17;
    localparam logic [op_i26_w-1:0]   op_i26_b      = 6'h14;
    localparam logic [op_i26_w-1:0]   op_i26_bl     = 6'h15;

    localparam logic [reg_aw-1:0] link_reg = 5'd1;   // ra

    typedef enum logic [7:0] {
        alu_nop,
        alu_add_w,
        alu_sub_w,
        alu_and,
        alu_or,
        alu_xor,
        alu_syscall,
        alu_break,
        alu_addi_w,
        alu_ld_w,
        alu_st_w,
        alu_andi,
        alu_ori,
        alu_lu12i_w,
        alu_pcaddu12i,
        alu_jirl,
        alu_beq,
        alu_bne,
        alu_b,
        alu_bl
    } alu_op_e;

    typedef enum logic [2:0] {
        sel_none,
        sel_arith,
        sel_logic,
        sel_mem,
        sel_branch,
        sel_jump
    } alu_sel_e;

    typedef enum logic [6:0] {
        exc_none  = 7'd0,
        exc_fetch = 7'd8,
        exc_sys   = 7'd11,
        exc_brk   = 7'd12,
        exc_ine   = 7'd13    // instruction not exist
    } exc_cause_e;

endpackage
